/* list.f */
+incdir+design
design/cpu_pkg.sv
design/control.sv
design/regFile.sv
design/alu.sv
design/decodeStage.sv
design/executeStage.sv
design/writebackStage.sv
design/wisCore.sv
tb/wisCore_checker.sv
tb/wisCore_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module wisCore_tb -o simv
out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED"

/* tb/wisCore_tb.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module wisCore_tb;

	localparam logic [4:0] OP_HALT = 5'd0, OP_J = 5'd4, OP_JR = 5'd5, OP_JAL = 5'd6;
	localparam logic [4:0] OP_JALR = 5'd7, OP_ADDI = 5'd8, OP_BEQZ = 5'd12, OP_BNEZ = 5'd13;
	localparam logic [4:0] OP_BLTZ = 5'd14, OP_BGEZ = 5'd15, OP_ST = 5'd16, OP_LD = 5'd17;
	localparam logic [4:0] OP_SLBI = 5'd18, OP_STU = 5'd19, OP_LBI = 5'd24, OP_ARR = 5'd27;

	logic clk, rst, instrValid;
	logic [15:0] instr, pc, redirectPc, wbData, fpc, redirTarget;
	logic redirectValid, err, halted, wbValid, redirSeen;
	logic [2:0] wbReg;
	logic [15:0] prog [256];
	logic [15:0] mReg [8];
	logic [15:0] mMem [256];
	logic [2:0] expReg [$];
	logic [15:0] expData [$];
	logic [15:0] redirQ [$];
	logic [31:0] seed;
	int n, errors, errBefore, cycles, wbCount, redirCount;

	wisCore UUT (.*);

	bind wisCore wisCore_checker checker0 (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [15:0] randBits();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed[31:16];
	endfunction

	function automatic logic [15:0] rotl(logic [15:0] x, logic [3:0] s);
		return (s == 0) ? x : ((x << s) | (x >> (16 - s)));
	endfunction

	function automatic logic [15:0] rotr(logic [15:0] x, logic [3:0] s);
		return (s == 0) ? x : ((x >> s) | (x << (16 - s)));
	endfunction

	function automatic logic [15:0] shiftBy(logic [1:0] kind, logic [15:0] x, logic [3:0] s);
		case (kind)
			2'd0: return rotl(x, s);
			2'd1: return x << s;
			2'd2: return rotr(x, s);
			default: return x >> s;
		endcase
	endfunction

	task automatic reportFail(input string msg);
		$display("FAIL %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic emit(input logic [15:0] w);
		prog[n] = w;
		n++;
	endtask

	// wrong-path filler, writes r5 if it ever executes.
	task automatic emitJunk();
		emit({OP_LBI, 3'd5, 8'(n)});
		emit({OP_LBI, 3'd5, 8'(n + 1)});
	endtask

	task automatic emitBranch(input logic [4:0] op, input logic [7:0] val);
		emit({OP_LBI, 3'd0, val});
		emit({op, 3'd0, 8'd4});
		emitJunk();
	endtask

	// --------------------------------------------------
	// program
	// --------------------------------------------------
	task automatic buildProgram();
		logic [15:0] rv;
		int op, f, r, k, base;
		n = 0;
		for (r = 0; r < 8; r++)
		begin
			rv = randBits();
			emit({OP_LBI, 3'(r), rv[7:0]});
			emit({OP_SLBI, 3'(r), rv[15:8]});
		end
		for (k = 0; k < 2; k++)
		begin
			for (op = 8; op < 24; op++)
			begin
				rv = randBits();
				if (op < 12 || op > 19)
					emit({5'(op), rv[2:0], rv[5:3], rv[10:6]});
			end
			for (op = 25; op < 32; op++)
				for (f = 0; f < 4; f++)
				begin
					rv = randBits();
					if (op == 26 || op == 27)
						emit({5'(op), rv[2:0], rv[5:3], rv[8:6], 2'(f)});
					else if (f == 0)
						emit({5'(op), rv[2:0], rv[5:3], rv[8:6], rv[10:9]});
				end
		end
		// back-to-back and distance-two chains.
		emit({OP_ARR, 3'd1, 3'd2, 3'd3, 2'd0});
		emit({OP_ARR, 3'd3, 3'd1, 3'd4, 2'd1});
		emit({OP_ARR, 3'd3, 3'd4, 3'd5, 2'd0});
		emit({OP_ADDI, 3'd5, 3'd3, 5'd7});
		// memory.
		emit({OP_LBI, 3'd6, 8'h10});
		emit({OP_ST, 3'd6, 3'd1, 5'd2});
		emit({OP_LD, 3'd6, 3'd2, 5'd2});
		emit({OP_STU, 3'd6, 3'd3, 5'd4});
		emit({OP_LD, 3'd6, 3'd4, 5'd0});
		emitBranch(OP_BEQZ, 8'h00);
		emitBranch(OP_BNEZ, 8'h00);
		emitBranch(OP_BLTZ, 8'hfd);
		emitBranch(OP_BGEZ, 8'hfd);
		emit({OP_J, 11'd4});
		emitJunk();
		emit({OP_JAL, 11'd4});
		emitJunk();
		base = 2 * n;
		emit({OP_LBI, 3'd3, 8'd0});
		emit({OP_SLBI, 3'd3, 8'(base + 10)});
		emit({OP_JR, 3'd3, 8'd0});
		emitJunk();
		base = 2 * n;
		emit({OP_LBI, 3'd3, 8'd0});
		emit({OP_SLBI, 3'd3, 8'(base + 6)});
		emit({OP_JALR, 3'd3, 8'd4});
		emitJunk();
		emit({OP_HALT, 11'd0});
		for (k = n; k < 256; k++)
			prog[k] = {OP_LBI, 3'(k), 8'(k)};
	endtask

	task automatic expectWrite(input logic [2:0] r, input logic [15:0] v);
		mReg[r] = v;
		expReg.push_back(r);
		expData.push_back(v);
	endtask

	// --------------------------------------------------
	// reference model, in program order
	// --------------------------------------------------
	task automatic buildExpect();
		logic [15:0] w, p, npc, a, b, s5, z5, s8, z8, s11, addr;
		logic [4:0] op;
		logic done;
		int steps;
		for (int i = 0; i < 8; i++)
			mReg[i] = '0;
		p = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 1000)
		begin
			w = prog[p[8:1]];
			op = w[15:11];
			a = mReg[w[10:8]];
			b = mReg[w[7:5]];
			s5 = {{11{w[4]}}, w[4:0]};
			z5 = {11'd0, w[4:0]};
			s8 = {{8{w[7]}}, w[7:0]};
			z8 = {8'd0, w[7:0]};
			s11 = {{5{w[10]}}, w[10:0]};
			addr = a + s5;
			npc = p + 16'd2;
			case (op)
				5'd0: done = 1'b1;
				5'd4, 5'd6: npc = p + 16'd2 + s11;
				5'd5, 5'd7: npc = a + s8;
				5'd8: expectWrite(w[7:5], a + s5);
				5'd9: expectWrite(w[7:5], s5 - a);
				5'd10: expectWrite(w[7:5], a ^ z5);
				5'd11: expectWrite(w[7:5], a & ~z5);
				5'd12: if (a == 0) npc = p + 16'd2 + s8;
				5'd13: if (a != 0) npc = p + 16'd2 + s8;
				5'd14: if (a[15]) npc = p + 16'd2 + s8;
				5'd15: if (!a[15]) npc = p + 16'd2 + s8;
				5'd16: mMem[addr[8:1]] = b;
				5'd17: expectWrite(w[7:5], mMem[addr[8:1]]);
				5'd18: expectWrite(w[10:8], (a << 8) | z8);
				5'd19:
				begin
					mMem[addr[8:1]] = b;
					expectWrite(w[10:8], addr);
				end
				5'd20, 5'd21, 5'd22, 5'd23: expectWrite(w[7:5], shiftBy(op[1:0], a, s5[3:0]));
				5'd24: expectWrite(w[10:8], s8);
				5'd25: expectWrite(w[4:2], {<<{a}});
				5'd26: expectWrite(w[4:2], shiftBy(w[1:0], a, b[3:0]));
				5'd27: expectWrite(w[4:2], (w[1:0] == 0) ? a + b : (w[1:0] == 1) ? b - a :
					(w[1:0] == 2) ? a ^ b : a & ~b);
				5'd28: expectWrite(w[4:2], 16'(a == b));
				5'd29: expectWrite(w[4:2], 16'($signed(a) < $signed(b)));
				5'd30: expectWrite(w[4:2], 16'($signed(a) <= $signed(b)));
				5'd31: expectWrite(w[4:2], 16'(({1'b0, a} + {1'b0, b}) >> 16));
				default: ;
			endcase
			if (op == 5'd6 || op == 5'd7)
				expectWrite(3'd7, p + 16'd2);
			if (npc != p + 16'd2)
				redirQ.push_back(npc);
			p = npc;
			steps++;
		end
	endtask

	// outputs sampled mid-cycle.
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (wbValid)
			begin
				assert (expReg.size() != 0)
					else reportFail("write-back seen with no write expected");
				if (expReg.size() != 0)
				begin
					assert (wbReg == expReg[0] && wbData == expData[0])
						else reportFail($sformatf("wb r%0d=%h, expected r%0d=%h",
							wbReg, wbData, expReg[0], expData[0]));
					void'(expReg.pop_front());
					void'(expData.pop_front());
					wbCount++;
				end
			end
			if (redirectValid)
			begin
				assert (redirQ.size() != 0 && redirectPc == redirQ[0])
					else reportFail($sformatf("redirect to %h not expected", redirectPc));
				if (redirQ.size() != 0)
					void'(redirQ.pop_front());
				redirCount++;
			end
			assert (!err) else reportFail("err pulse on a legal opcode");
			redirSeen = redirectValid;
			redirTarget = redirectPc;
		end
	end

	task automatic fetchNext();
		@(posedge clk);
		#1;
		fpc = redirSeen ? redirTarget : fpc + 16'd2;
		instr = prog[fpc[8:1]];
		pc = fpc;
	endtask

	initial
	begin
		seed = 32'hb0b8_0d8c;
		errors = 0;
		wbCount = 0;
		redirCount = 0;
		rst = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		redirSeen = 1'b0;
		redirTarget = '0;
		buildProgram();
		buildExpect();
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		assert (!wbValid && !redirectValid && !err && !halted)
			else reportFail("outputs not low after reset");
		$display("test reset: %0d errors", errors);

		errBefore = errors;
		fpc = '0;
		instr = prog[0];
		pc = fpc;
		instrValid = 1'b1;
		cycles = 0;
		while (!halted && cycles < 2000)
		begin
			fetchNext();
			cycles++;
		end
		if (!halted)
		begin
			$display("timeout: halted did not rise within 2000 cycles");
			errors++;
		end
		$display("test program: %0d errors", errors - errBefore);

		// words after halt must never write back.
		errBefore = errors;
		cycles = 0;
		while (cycles < 10)
		begin
			fetchNext();
			cycles++;
		end
		assert (expReg.size() == 0 && redirQ.size() == 0 && halted)
			else reportFail("missing write-backs or redirects at halt");
		$display("test halt: %0d errors", errors - errBefore);
		$display("done: %0d write-backs, %0d redirects, %0d errors", wbCount, redirCount, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* tb/wisCore_checker.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module wisCore_checker (
	input logic clk,
	input logic rst,
	input logic wbValid,
	input logic err,
	input logic redirectValid,
	input logic halted,
	input logic [`REG_W-1:0] wbReg,
	input logic [`WORD_W-1:0] wbData
);

	// outputs quiet once reset has been seen for a full cycle.
	resetQuiet: assert property (@(posedge clk)
		rst && $past(rst) |-> !wbValid && !err && !redirectValid)
		else $error("write-back, err or redirect active during reset");

	haltSticky: assert property (@(posedge clk) disable iff (rst) !$fell(halted))
		else $error("halted fell without reset");

	errRedirect: assert property (@(posedge clk) disable iff (rst) !(err && redirectValid))
		else $error("err and redirectValid high together");

	wbKnown: assert property (@(posedge clk) disable iff (rst)
		wbValid |-> !$isunknown({wbReg, wbData}))
		else $error("unknown write-back register or data");

endmodule

/* design/wisCore.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module wisCore (
	input logic clk,
	input logic rst,
	input logic instrValid,
	input logic [`WORD_W-1:0] instr,
	input logic [`WORD_W-1:0] pc,
	output logic redirectValid,
	output logic [`WORD_W-1:0] redirectPc,
	output logic err,
	output logic halted,
	output logic wbValid,
	output logic [`REG_W-1:0] wbReg,
	output logic [`WORD_W-1:0] wbData
);
	import cpu_pkg::*;

	deState_t de;
	ewState_t ew;
	wbBus_t wb;
	logic squash;

	decodeStage decode (
		.clk(clk),
		.rst(rst),
		.instrValid(instrValid),
		.instr(instr),
		.pc(pc),
		.squash(squash),
		.wb(wb),
		.de(de)
	);

	executeStage execute (
		.clk(clk),
		.rst(rst),
		.de(de),
		.wb(wb),
		.ew(ew),
		.squash(squash),
		.redirectValid(redirectValid),
		.redirectPc(redirectPc),
		.err(err),
		.halted(halted)
	);

	writebackStage writeback (
		.ew(ew),
		.wb(wb),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

endmodule

/* design/writebackStage.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module writebackStage (
	input cpu_pkg::ewState_t ew,
	output cpu_pkg::wbBus_t wb,
	output logic wbValid,
	output logic [`REG_W-1:0] wbReg,
	output logic [`WORD_W-1:0] wbData
);

	// only real register writes go out.
	assign wb.valid = ew.valid & ew.regWrite;
	assign wb.dest = ew.dest;
	assign wb.data = ew.data;

	// trace port.
	assign wbValid = wb.valid;
	assign wbReg = wb.dest;
	assign wbData = wb.data;

endmodule

/* design/executeStage.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module executeStage (
	input logic clk,
	input logic rst,
	input cpu_pkg::deState_t de,
	input cpu_pkg::wbBus_t wb,
	output cpu_pkg::ewState_t ew,
	output logic squash,
	output logic redirectValid,
	output logic [`WORD_W-1:0] redirectPc,
	output logic err,
	output logic halted
);
	import cpu_pkg::*;

	logic [`WORD_W-1:0] opA, opB, aluB, aluRes;
	logic [`WORD_W-1:0] pcInc, memAddr, memRd, wrData;
	logic [`WORD_W-1:0] dmem [`DMEM_DEPTH];
	logic taken, haltNow;
	ewState_t ewNext;

	// --------------------------------------------------
	// operands
	// --------------------------------------------------
	assign opA = (wb.valid && wb.dest == de.rs) ? wb.data : de.rsVal;
	assign opB = (wb.valid && wb.dest == de.rt) ? wb.data : de.rtVal;
	assign aluB = de.ctrl.aluSrc ? de.imm : opB;

	alu alu0 (
		.aluOp(de.ctrl.aluOp),
		.func(de.func),
		.a(opA),
		.b(aluB),
		.result(aluRes)
	);

	// beqz, bnez, bltz, bgez on rs.
	always_comb
	begin
		case (de.ctrl.aluOp[1:0])
			2'b00: taken = (opA == '0);
			2'b01: taken = (opA != '0);
			2'b10: taken = opA[`WORD_W-1];
			default: taken = ~opA[`WORD_W-1];
		endcase
	end

	assign pcInc = de.pc + `WORD_W'(2);
	assign redirectValid = de.valid & (de.ctrl.jump | (de.ctrl.branch & taken));
	// jr and jalr are register relative.
	assign redirectPc = (de.ctrl.jump & de.ctrl.aluSrc) ? opA + de.imm : pcInc + de.imm;
	assign err = de.valid & de.ctrl.err;
	assign haltNow = de.valid & de.ctrl.halt & ~de.ctrl.err;
	assign squash = redirectValid | haltNow | halted;

	always_ff @(posedge clk)
	begin
		if (rst)
			halted <= 1'b0;
		else if (haltNow)
			halted <= 1'b1;
	end

	// --------------------------------------------------
	// data memory
	// --------------------------------------------------
	assign memAddr = opA + de.imm;
	assign memRd = de.ctrl.memRead ? dmem[memAddr[`DMEM_AW:1]] : '0;

	always_ff @(posedge clk)
	begin
		if (!rst && de.valid && de.ctrl.memWrite)
			dmem[memAddr[`DMEM_AW:1]] <= opB;
	end

	// stu hands back the address.
	always_comb
	begin
		if (de.ctrl.jump)
			wrData = pcInc;
		else if (de.ctrl.memWrite)
			wrData = memAddr;
		else if (de.ctrl.memToReg)
			wrData = memRd;
		else
			wrData = aluRes;
	end

	assign ewNext = '{valid: de.valid, regWrite: de.ctrl.regWrite, dest: de.dest,
		data: wrData};

	always_ff @(posedge clk)
	begin
		ew <= ewNext;
		if (rst)
			ew.valid <= 1'b0;
	end

endmodule

/* design/decodeStage.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module decodeStage (
	input logic clk,
	input logic rst,
	input logic instrValid,
	input logic [`WORD_W-1:0] instr,
	input logic [`WORD_W-1:0] pc,
	input logic squash,
	input cpu_pkg::wbBus_t wb,
	output cpu_pkg::deState_t de
);
	import cpu_pkg::*;

	fdState_t fd;
	ctrl_t ctrl;
	logic [`REG_W-1:0] rs, rt, rd, dest;
	logic [`WORD_W-1:0] imm, rsVal, rtVal;
	deState_t deNext;

	always_ff @(posedge clk)
	begin
		fd <= '{valid: instrValid & ~squash, pc: pc, instr: instr};
		if (rst)
			fd.valid <= 1'b0;
	end

	control decoder (
		.opcode(fd.instr[15:11]),
		.ctrl(ctrl)
	);

	assign rs = fd.instr[10:8];
	assign rt = fd.instr[7:5];
	assign rd = fd.instr[4:2];

	// immediate by format, msb kept unless zeroExt.
	always_comb
	begin
		if (ctrl.i1Fmt)
			imm = {{(`WORD_W-5){fd.instr[4] & ~ctrl.zeroExt}}, fd.instr[4:0]};
		else if (ctrl.jump & ~ctrl.aluSrc)
			imm = {{(`WORD_W-11){fd.instr[10] & ~ctrl.zeroExt}}, fd.instr[10:0]};
		else
			imm = {{(`WORD_W-8){fd.instr[7] & ~ctrl.zeroExt}}, fd.instr[7:0]};
	end

	// stu is i1-format but writes the base register.
	always_comb
	begin
		if (ctrl.regDst)
			dest = rd;
		else if (ctrl.jump)
			dest = `REG_W'(`LINK_REG);
		else if (ctrl.i1Fmt & ~ctrl.memWrite)
			dest = rt;
		else
			dest = rs;
	end

	regFile regs (
		.clk(clk),
		.rst(rst),
		.wb(wb),
		.rdAddrA(rs),
		.rdAddrB(rt),
		.rdDataA(rsVal),
		.rdDataB(rtVal)
	);

	assign deNext = '{valid: fd.valid & ~squash, pc: fd.pc, ctrl: ctrl, rs: rs, rt: rt,
		dest: dest, rsVal: rsVal, rtVal: rtVal, imm: imm, func: fd.instr[1:0]};

	always_ff @(posedge clk)
	begin
		de <= deNext;
		if (rst)
			de.valid <= 1'b0;
	end

endmodule

/* design/alu.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module alu (
	input logic [`OP_W-1:0] aluOp,
	input logic [1:0] func,
	input logic [`WORD_W-1:0] a,
	input logic [`WORD_W-1:0] b,
	output logic [`WORD_W-1:0] result
);

	logic [1:0] sel;
	logic [3:0] sh;
	logic [2*`WORD_W-1:0] rolWide, rorWide;
	logic [`WORD_W:0] sum;
	logic [`WORD_W-1:0] arithRes, shiftRes, rev;
	logic lt, eq;

	// r-format groups take the func field, immediates the low opcode bits.
	assign sel = (aluOp[4:1] == 4'b1101) ? func : aluOp[1:0];
	assign sh = b[3:0];
	assign rolWide = {a, a} << sh;
	assign rorWide = {a, a} >> sh;
	assign sum = {1'b0, a} + {1'b0, b};
	assign lt = $signed(a) < $signed(b);
	assign eq = (a == b);

	always_comb
	begin
		for (int i = 0; i < `WORD_W; i++)
			rev[i] = a[`WORD_W-1-i];
	end

	always_comb
	begin
		case (sel)
			2'b00: arithRes = sum[`WORD_W-1:0];
			2'b01: arithRes = b - a;
			2'b10: arithRes = a ^ b;
			default: arithRes = a & ~b;
		endcase
	end

	always_comb
	begin
		case (sel)
			2'b00: shiftRes = rolWide[2*`WORD_W-1:`WORD_W];
			2'b01: shiftRes = a << sh;
			2'b10: shiftRes = rorWide[`WORD_W-1:0];
			default: shiftRes = a >> sh;
		endcase
	end

	// --------------------------------------------------
	// result select
	// --------------------------------------------------
	always_comb
	begin
		case (aluOp)
			5'b0_1000, 5'b0_1001, 5'b0_1010, 5'b0_1011, 5'b1_1011:
				result = arithRes;
			5'b1_0100, 5'b1_0101, 5'b1_0110, 5'b1_0111, 5'b1_1010:
				result = shiftRes;
			5'b1_1100:
				result = `WORD_W'(eq);
			5'b1_1101:
				result = `WORD_W'(lt);
			5'b1_1110:
				result = `WORD_W'(lt | eq);
			5'b1_1111:
				result = `WORD_W'(sum[`WORD_W]);
			5'b1_1001:
				result = rev;
			5'b1_1000:
				result = b;
			5'b1_0010:
				result = (a << 8) | b;
			default:
				result = sum[`WORD_W-1:0];
		endcase
	end

endmodule

/* design/regFile.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module regFile (
	input logic clk,
	input logic rst,
	input cpu_pkg::wbBus_t wb,
	input logic [`REG_W-1:0] rdAddrA,
	input logic [`REG_W-1:0] rdAddrB,
	output logic [`WORD_W-1:0] rdDataA,
	output logic [`WORD_W-1:0] rdDataB
);

	logic [`REG_CNT-1:0][`WORD_W-1:0] regs;

	always_ff @(posedge clk)
	begin
		if (rst)
			regs <= '0;
		else if (wb.valid)
			regs[wb.dest] <= wb.data;
	end

	// write-through so a same-cycle read sees the new value.
	assign rdDataA = (wb.valid && wb.dest == rdAddrA) ? wb.data : regs[rdAddrA];
	assign rdDataB = (wb.valid && wb.dest == rdAddrB) ? wb.data : regs[rdAddrB];

endmodule

/* design/control.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module control (
	input logic [`OP_W-1:0] opcode,
	output cpu_pkg::ctrl_t ctrl
);

	always_comb
	begin
		ctrl = '0;
		ctrl.aluOp = opcode;
		case (opcode)
			// halt, nop, siic, rti.
			5'b0_0000:
			begin
				ctrl.halt = 1'b1;
			end
			5'b0_0001, 5'b0_0010, 5'b0_0011:
			begin
			end
			// --------------------------------------------------
			// i-format 1
			// --------------------------------------------------
			5'b0_1000, 5'b0_1001, 5'b1_0100, 5'b1_0101, 5'b1_0110, 5'b1_0111:
			begin
				ctrl.i1Fmt = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			5'b0_1010, 5'b0_1011:
			begin
				ctrl.i1Fmt = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.zeroExt = 1'b1;
			end
			// st.
			5'b1_0000:
			begin
				ctrl.i1Fmt = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
			end
			// ld.
			5'b1_0001:
			begin
				ctrl.i1Fmt = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			// stu.
			5'b1_0011:
			begin
				ctrl.i1Fmt = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.memWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			// --------------------------------------------------
			// r-format
			// --------------------------------------------------
			5'b1_1001, 5'b1_1010, 5'b1_1011, 5'b1_1100, 5'b1_1101, 5'b1_1110, 5'b1_1111:
			begin
				ctrl.regDst = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			// i-format 2, branches then lbi and slbi.
			5'b0_1100, 5'b0_1101, 5'b0_1110, 5'b0_1111:
			begin
				ctrl.aluSrc = 1'b1;
				ctrl.branch = 1'b1;
			end
			5'b1_1000:
			begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			5'b1_0010:
			begin
				ctrl.aluSrc = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.zeroExt = 1'b1;
			end
			// jumps.
			5'b0_0100:
			begin
				ctrl.jump = 1'b1;
			end
			5'b0_0101:
			begin
				ctrl.jump = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			5'b0_0110:
			begin
				ctrl.jump = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			5'b0_0111:
			begin
				ctrl.jump = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			default:
			begin
				ctrl.err = 1'b1;
			end
		endcase
	end

endmodule

/* design/cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

	// decoder outputs.
	typedef struct packed {
		logic regDst;
		logic aluSrc;
		logic branch;
		logic memRead;
		logic memWrite;
		logic jump;
		logic memToReg;
		logic regWrite;
		logic err;
		logic halt;
		logic zeroExt;
		logic i1Fmt;
		logic [`OP_W-1:0] aluOp;
	} ctrl_t;

	// --------------------------------------------------
	// stage registers
	// --------------------------------------------------
	typedef struct packed {
		logic valid;
		logic [`WORD_W-1:0] pc;
		logic [`WORD_W-1:0] instr;
	} fdState_t;

	typedef struct packed {
		logic valid;
		logic [`WORD_W-1:0] pc;
		ctrl_t ctrl;
		logic [`REG_W-1:0] rs;
		logic [`REG_W-1:0] rt;
		logic [`REG_W-1:0] dest;
		logic [`WORD_W-1:0] rsVal;
		logic [`WORD_W-1:0] rtVal;
		logic [`WORD_W-1:0] imm;
		logic [1:0] func;
	} deState_t;

	typedef struct packed {
		logic valid;
		logic regWrite;
		logic [`REG_W-1:0] dest;
		logic [`WORD_W-1:0] data;
	} ewState_t;

	// register write port, also the forwarding source.
	typedef struct packed {
		logic valid;
		logic [`REG_W-1:0] dest;
		logic [`WORD_W-1:0] data;
	} wbBus_t;

endpackage

/* design/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and instruction width.
`define WORD_W 16
`define OP_W 5

// register file.
`define REG_CNT 8
`define REG_W 3
`define LINK_REG 7

// data memory, word addressed by address bits 8 to 1.
`define DMEM_DEPTH 256
`define DMEM_AW 8

`endif
